//--- common/vid_regs_pkg.sv
// =========================================================================
// video renderer register map
// register word indices, CPU address regions and RAM sizes, plus the
// configuration set that the renderer and the fetcher read
// =========================================================================
package vid_regs_pkg;

	// register word indices, regs region
	localparam int REG_FB_ADDR = 0;
	localparam int REG_FB_PITCH = 1;
	localparam int REG_LAYER_EN = 2;
	localparam int REG_TILE_OFF = 3;
	localparam int REG_VIDPOS = 4; // read only

	// byte bases of the CPU regions
	localparam logic [15:0] BASE_REGS = 16'h0000;
	localparam logic [15:0] BASE_PALETTE = 16'h1000;
	localparam logic [15:0] BASE_TILEMAP = 16'h2000;
	localparam logic [15:0] BASE_TILEMEM = 16'h4000;

	localparam int PAL_ENTRIES = 32; // 16 fb colours, then 16 tile colours
	localparam int MAP_ENTRIES = 256; // 16x16 map
	localparam int TILE_ROWS = 512; // 64 tiles of 8 rows

	typedef struct packed {
		logic [23:0] fb_addr; // word address of line 0
		logic [15:0] pitch; // in words
		logic [1:0] layer_en; // bit0 fb, bit1 tiles
		logic [15:0] tile_xoff;
		logic [15:0] tile_yoff;
	} vid_cfg_t;

	typedef struct packed {
		logic [8:0] line;
		logic [8:0] x;
	} render_pos_t;

endpackage

//--- common/vid_bus_pkg.sv
// =========================================================================
// video renderer bus types
// framebuffer words, pixels, external memory and line buffer transfers
// =========================================================================
package vid_bus_pkg;

	// 8 pixels of 4 bits, pixel k in nibble k
	typedef logic [31:0] fb_word_t;

	typedef logic [23:0] rgb_t;

	typedef logic [5:0] tile_no_t;

	// memory read request, valid/ready handshake
	typedef struct packed {
		logic valid;
		logic [23:0] addr;
	} mem_req_t;

	// read data, in request order and without back-pressure
	typedef struct packed {
		logic valid;
		fb_word_t data;
	} mem_rsp_t;

	// one pixel into the external line buffer
	typedef struct packed {
		logic valid;
		logic [8:0] line;
		logic [8:0] x;
		rgb_t rgb;
	} lb_wr_t;

endpackage

//--- source/vid_dpram.sv
// =========================================================================
// dual-port synchronous RAM
// port A for CPU access, port B for the renderer, one cycle read latency
// =========================================================================
`timescale 1ns/1ps

module vid_dpram #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 256,
	localparam int AW = $clog2(DEPTH)
) (
	input logic clk,
	input logic a_we,
	input logic [AW-1:0] a_addr,
	input payload_t a_wdata,
	output payload_t a_q,
	input logic [AW-1:0] b_addr,
	output payload_t b_q
);

	payload_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (a_we)
			mem[a_addr] <= a_wdata;
		a_q <= mem[a_addr]; // old data on a write
		b_q <= mem[b_addr];
	end

endmodule

//--- source/vid_apb_regs.sv
// =========================================================================
// APB register slave
// configuration registers, CPU access to palette, tile map and tile
// memory, one wait state per access, error on unmapped or read-only
// =========================================================================
`timescale 1ns/1ps

module vid_apb_regs #(
	parameter int H_PIXELS = 64
) (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [15:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output vid_regs_pkg::vid_cfg_t cfg,
	input vid_regs_pkg::render_pos_t pos,
	output logic pal_we,
	output logic map_we,
	output logic tile_we,
	output logic [8:0] cpu_addr,
	output logic [31:0] cpu_wdata,
	input vid_bus_pkg::rgb_t pal_q,
	input vid_bus_pkg::tile_no_t map_q,
	input vid_bus_pkg::fb_word_t tile_q
);
	import vid_regs_pkg::*;

	logic [9:0] reg_idx;
	logic reg_ok;
	logic pal_ok;
	logic map_ok;
	logic tile_ok;
	logic err;
	logic access1;
	logic wr_ok;
	logic [31:0] rdata;

	assign reg_idx = paddr[11:2];

	// region decode, then bound check inside the region
	assign reg_ok = (paddr[15:12] == BASE_REGS[15:12]) && (reg_idx <= REG_VIDPOS);
	assign pal_ok = (paddr[15:12] == BASE_PALETTE[15:12]) && (paddr[11:2] < PAL_ENTRIES);
	assign map_ok = (paddr[15:13] == BASE_TILEMAP[15:13]) && (paddr[12:2] < MAP_ENTRIES);
	assign tile_ok = (paddr[15:14] == BASE_TILEMEM[15:14]) && (paddr[13:2] < TILE_ROWS);

	assign err = !(reg_ok || pal_ok || map_ok || tile_ok) ||
		(reg_ok && reg_idx == REG_VIDPOS && pwrite);

	assign access1 = psel && penable && !pready; // first access cycle
	assign wr_ok = access1 && pwrite && !err;

	// RAM port A, address held for the whole access
	assign cpu_addr = paddr[10:2];
	assign cpu_wdata = pwdata;
	assign pal_we = wr_ok && pal_ok;
	assign map_we = wr_ok && map_ok;
	assign tile_we = wr_ok && tile_ok;

	always_ff @(posedge clk) begin
		if (reset) begin
			pready <= 1'b0;
			cfg <= '{
				fb_addr: '0,
				pitch: 16'(H_PIXELS / 8),
				layer_en: '0,
				tile_xoff: '0,
				tile_yoff: '0
			};
		end else begin
			pready <= access1;
			if (wr_ok && reg_ok) begin
				case (reg_idx)
					REG_FB_ADDR: cfg.fb_addr <= pwdata[23:0];
					REG_FB_PITCH: cfg.pitch <= pwdata[15:0];
					REG_LAYER_EN: cfg.layer_en <= pwdata[1:0];
					REG_TILE_OFF: begin
						cfg.tile_xoff <= pwdata[15:0];
						cfg.tile_yoff <= pwdata[31:16];
					end
					default: ; // VIDPOS never gets here
				endcase
			end
		end
	end

	// read mux, RAM data is valid in the second cycle
	always_comb begin
		rdata = '0;
		if (reg_ok) begin
			case (reg_idx)
				REG_FB_ADDR: rdata = {8'h0, cfg.fb_addr};
				REG_FB_PITCH: rdata = {16'h0, cfg.pitch};
				REG_LAYER_EN: rdata = {30'h0, cfg.layer_en};
				REG_TILE_OFF: rdata = {cfg.tile_yoff, cfg.tile_xoff};
				REG_VIDPOS: rdata = {7'h0, pos.line, 7'h0, pos.x};
				default: rdata = '0;
			endcase
		end else if (pal_ok) begin
			rdata = {8'h0, pal_q};
		end else if (map_ok) begin
			rdata = {26'h0, map_q};
		end else if (tile_ok) begin
			rdata = tile_q;
		end
	end

	assign prdata = pready ? rdata : '0;
	assign pslverr = pready && err;

	// access phase only after a setup phase
	a_apb_setup: assert property (@(posedge clk) disable iff (reset)
		$rose(penable) |-> psel && $past(psel));

endmodule

//--- fb_fetch/fb_fetch.sv
// =========================================================================
// framebuffer fetcher
// walks the lines of one frame and issues pipelined word reads, limited
// by free FIFO space, and forwards read data into the FIFO
// =========================================================================
`timescale 1ns/1ps

module fb_fetch #(
	parameter int H_PIXELS = 64,
	parameter int V_LINES = 8,
	parameter int FIFO_DEPTH = 4,
	localparam int CW = $clog2(FIFO_DEPTH + 1)
) (
	input logic clk,
	input logic reset,
	input vid_regs_pkg::vid_cfg_t cfg,
	input logic frame_start,
	output vid_bus_pkg::mem_req_t mem_req,
	input logic mem_req_ready,
	input vid_bus_pkg::mem_rsp_t mem_rsp,
	output logic push,
	output vid_bus_pkg::fb_word_t push_data,
	input logic [CW-1:0] fifo_count
);

	localparam int WPL = H_PIXELS / 8; // words per line
	localparam int WW = $clog2(WPL + 1);
	localparam int LW = $clog2(V_LINES + 1);

	logic active;
	logic [23:0] line_base; // fb_addr + line * pitch
	logic [15:0] pitch_q;
	logic [WW-1:0] word_idx;
	logic [LW-1:0] line_idx;
	logic [CW-1:0] inflight;
	logic [CW:0] occupancy;
	logic issue;
	logic last_word;

	// requests out plus words held may never exceed the FIFO
	assign occupancy = inflight + fifo_count;

	assign mem_req = '{
		valid: active && (occupancy < FIFO_DEPTH),
		addr: line_base + 24'(word_idx)
	};
	assign issue = mem_req.valid && mem_req_ready;
	assign last_word = (word_idx == WW'(WPL - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			inflight <= '0;
			word_idx <= '0;
			line_idx <= '0;
		end else begin
			inflight <= inflight + CW'(issue) - CW'(mem_rsp.valid);
			if (frame_start) begin
				active <= 1'b1;
				word_idx <= '0;
				line_idx <= '0;
			end else if (issue) begin
				if (last_word) begin
					word_idx <= '0;
					line_idx <= line_idx + 1'b1;
					if (line_idx == LW'(V_LINES - 1))
						active <= 1'b0; // whole frame requested
				end else begin
					word_idx <= word_idx + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (frame_start) begin
			line_base <= cfg.fb_addr;
			pitch_q <= cfg.pitch;
		end else if (issue && last_word) begin
			line_base <= line_base + 24'(pitch_q);
		end
	end

	assign push = mem_rsp.valid;
	assign push_data = mem_rsp.data;

	a_credit: assert property (@(posedge clk) disable iff (reset)
		occupancy <= FIFO_DEPTH);

	// memory answers only what was asked
	a_rsp_expected: assert property (@(posedge clk) disable iff (reset)
		mem_rsp.valid |-> inflight != '0);

endmodule

//--- source/vid_word_fifo.sv
// =========================================================================
// synchronous first-word-fall-through FIFO
// head entry is visible on pop_data whenever the FIFO is not empty
// =========================================================================
`timescale 1ns/1ps

module vid_word_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 4,
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1,
	localparam int CW = $clog2(DEPTH + 1)
) (
	input logic clk,
	input logic reset,
	input logic push,
	input payload_t push_data,
	input logic pop,
	output payload_t pop_data,
	output logic empty,
	output logic [CW-1:0] count
);

	payload_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;

	function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			count <= count + CW'(push) - CW'(pop);
		end
	end

	assign pop_data = mem[rd_ptr];
	assign empty = (count == '0);

	// producer credit keeps pushes in bounds
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		push |-> count < DEPTH);

	a_no_underflow: assert property (@(posedge clk) disable iff (reset)
		pop |-> !empty);

endmodule

//--- line_render/line_render.sv
// =========================================================================
// line renderer
// composites the framebuffer and one scrolled tile layer through the
// palette, four cycles per pixel, into the external line buffer
// =========================================================================
`timescale 1ns/1ps

module line_render #(
	parameter int H_PIXELS = 64,
	parameter int V_LINES = 8
) (
	input logic clk,
	input logic reset,
	input vid_regs_pkg::vid_cfg_t cfg,
	input logic next_field,
	input logic [1:0] disp_line,
	output logic frame_start,
	input logic fifo_empty,
	output logic fifo_pop,
	input vid_bus_pkg::fb_word_t fifo_data,
	output logic [7:0] map_addr,
	output logic [8:0] tile_addr,
	output logic [4:0] pal_addr,
	input vid_bus_pkg::tile_no_t map_q,
	input vid_bus_pkg::fb_word_t tile_q,
	input vid_bus_pkg::rgb_t pal_q,
	output vid_bus_pkg::lb_wr_t lb_wr,
	output vid_regs_pkg::render_pos_t pos
);
	import vid_bus_pkg::*;

	logic [8:0] line; // V_LINES when idle
	logic [8:0] x;
	logic [1:0] phase;
	logic idle;
	logic at_word;
	logic at_line;
	logic go;
	fb_word_t fb_word;
	logic [15:0] tx;
	logic [15:0] ty;
	logic [3:0] fb_nib;
	logic [3:0] tile_nib;
	logic [3:0] tile_nib_q;
	rgb_t fb_rgb;
	logic pend; // palette result of the tile lookup due
	logic [8:0] out_line;
	logic [8:0] out_x;

	assign idle = (line == 9'(V_LINES));
	assign at_word = (phase == 2'd0) && (x[2:0] == 3'd0);
	assign at_line = (phase == 2'd0) && (x == '0);

	// stall at a word start without data, or at a line still on display
	assign go = !idle && !(at_word && fifo_empty) &&
		!(at_line && line[1:0] == disp_line);
	assign fifo_pop = go && at_word;

	// scrolled tile layer coordinates
	assign tx = 16'(x) + cfg.tile_xoff;
	assign ty = 16'(line) + cfg.tile_yoff;

	assign fb_nib = fb_word[{x[2:0], 2'b00} +: 4];
	assign tile_nib = tile_q[{tx[2:0], 2'b00} +: 4];

	// phase 0 map, phase 1 tile row, phase 2 fb colour, phase 3 tile colour
	assign map_addr = {ty[6:3], tx[6:3]}; // map wraps at 16 tiles
	assign tile_addr = {map_q, ty[2:0]};
	assign pal_addr = (phase == 2'd2) ? {1'b0, fb_nib} : {1'b1, tile_nib_q};

	always_ff @(posedge clk) begin
		if (reset) begin
			line <= 9'(V_LINES);
			x <= '0;
			phase <= '0;
			frame_start <= 1'b0;
			pend <= 1'b0;
		end else begin
			frame_start <= idle && next_field;
			pend <= go && (phase == 2'd3);
			if (idle) begin
				if (next_field)
					line <= '0; // x and phase already at 0
			end else if (go) begin
				phase <= phase + 2'd1;
				if (phase == 2'd3) begin
					if (x == 9'(H_PIXELS - 1)) begin
						x <= '0;
						line <= line + 9'd1; // reaches V_LINES at frame end
					end else begin
						x <= x + 9'd1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fifo_pop)
			fb_word <= fifo_data;
		if (phase == 2'd2)
			tile_nib_q <= tile_nib;
		if (phase == 2'd3) begin
			fb_rgb <= cfg.layer_en[0] ? pal_q : '0;
			out_line <= line;
			out_x <= x;
		end
	end

	// tile colour wins unless transparent
	always_comb begin
		lb_wr.valid = pend;
		lb_wr.line = out_line;
		lb_wr.x = out_x;
		lb_wr.rgb = (cfg.layer_en[1] && tile_nib_q != 4'd0) ? pal_q : fb_rgb;
	end

	assign pos = '{line: line, x: x};

	a_x_range: assert property (@(posedge clk) disable iff (reset)
		lb_wr.valid |-> lb_wr.x < H_PIXELS && lb_wr.line < V_LINES);

endmodule

//--- source/vid_render_top.sv
// =========================================================================
// video line renderer top level
// APB registers, palette and tile RAMs, framebuffer fetcher, word FIFO
// and the compositing line renderer
// =========================================================================
`timescale 1ns/1ps

module vid_render_top #(
	parameter int H_PIXELS = 64,
	parameter int V_LINES = 8,
	parameter int FIFO_DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [15:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output vid_bus_pkg::mem_req_t mem_req,
	input logic mem_req_ready,
	input vid_bus_pkg::mem_rsp_t mem_rsp,
	input logic next_field,
	input logic [1:0] disp_line,
	output vid_bus_pkg::lb_wr_t lb_wr
);
	import vid_regs_pkg::*;
	import vid_bus_pkg::*;

	vid_cfg_t cfg;
	render_pos_t pos;
	logic pal_we;
	logic map_we;
	logic tile_we;
	logic [8:0] cpu_addr;
	logic [31:0] cpu_wdata;
	rgb_t pal_cpu_q;
	tile_no_t map_cpu_q;
	fb_word_t tile_cpu_q;
	logic [4:0] pal_addr;
	logic [7:0] map_addr;
	logic [8:0] tile_addr;
	rgb_t pal_q;
	tile_no_t map_q;
	fb_word_t tile_q;
	logic frame_start;
	logic push;
	fb_word_t push_data;
	logic fifo_pop;
	fb_word_t fifo_data;
	logic fifo_empty;
	logic [$clog2(FIFO_DEPTH + 1)-1:0] fifo_count;

	vid_apb_regs #(.H_PIXELS(H_PIXELS)) u_regs (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.cfg(cfg), .pos(pos),
		.pal_we(pal_we), .map_we(map_we), .tile_we(tile_we),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.pal_q(pal_cpu_q), .map_q(map_cpu_q), .tile_q(tile_cpu_q)
	);

	vid_dpram #(.payload_t(rgb_t), .DEPTH(PAL_ENTRIES)) u_palette (
		.clk(clk),
		.a_we(pal_we), .a_addr(cpu_addr[4:0]), .a_wdata(cpu_wdata[23:0]),
		.a_q(pal_cpu_q),
		.b_addr(pal_addr), .b_q(pal_q)
	);

	vid_dpram #(.payload_t(tile_no_t), .DEPTH(MAP_ENTRIES)) u_tilemap (
		.clk(clk),
		.a_we(map_we), .a_addr(cpu_addr[7:0]), .a_wdata(cpu_wdata[5:0]),
		.a_q(map_cpu_q),
		.b_addr(map_addr), .b_q(map_q)
	);

	vid_dpram #(.payload_t(fb_word_t), .DEPTH(TILE_ROWS)) u_tilemem (
		.clk(clk),
		.a_we(tile_we), .a_addr(cpu_addr), .a_wdata(cpu_wdata),
		.a_q(tile_cpu_q),
		.b_addr(tile_addr), .b_q(tile_q)
	);

	fb_fetch #(
		.H_PIXELS(H_PIXELS), .V_LINES(V_LINES), .FIFO_DEPTH(FIFO_DEPTH)
	) u_fetch (
		.clk(clk), .reset(reset),
		.cfg(cfg), .frame_start(frame_start),
		.mem_req(mem_req), .mem_req_ready(mem_req_ready), .mem_rsp(mem_rsp),
		.push(push), .push_data(push_data), .fifo_count(fifo_count)
	);

	vid_word_fifo #(.payload_t(fb_word_t), .DEPTH(FIFO_DEPTH)) u_fifo (
		.clk(clk), .reset(reset),
		.push(push), .push_data(push_data),
		.pop(fifo_pop), .pop_data(fifo_data),
		.empty(fifo_empty), .count(fifo_count)
	);

	line_render #(.H_PIXELS(H_PIXELS), .V_LINES(V_LINES)) u_render (
		.clk(clk), .reset(reset),
		.cfg(cfg), .next_field(next_field), .disp_line(disp_line),
		.frame_start(frame_start),
		.fifo_empty(fifo_empty), .fifo_pop(fifo_pop), .fifo_data(fifo_data),
		.map_addr(map_addr), .tile_addr(tile_addr), .pal_addr(pal_addr),
		.map_q(map_q), .tile_q(tile_q), .pal_q(pal_q),
		.lb_wr(lb_wr), .pos(pos)
	);

endmodule

//--- verif/vid_tb_clock.sv
// ==========================================================================
// testbench clock and reset
// 10 ns clock, reset held high for the first 4 cycles
// ==========================================================================
`timescale 1ns/1ps

module vid_tb_clock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0; // released away from the rising edge
	end

endmodule

//--- verif/vid_tb_mem.sv
// ==========================================================================
// external memory model
// random word image, in-order read responses after 1 to 6 cycles,
// request ready dropped at random
// ==========================================================================
`timescale 1ns/1ps

module vid_tb_mem (
	input logic clk,
	input logic reset,
	input vid_bus_pkg::mem_req_t mem_req,
	output logic mem_req_ready,
	output vid_bus_pkg::mem_rsp_t mem_rsp
);
	import vid_bus_pkg::*;

	logic [31:0] img [4096];
	logic [23:0] addr_q [$];
	int due_q [$];
	int cycle;
	int last_due;
	int due;

	// upper address bits folded in so every address reads its own word
	function automatic fb_word_t word_at(input logic [23:0] addr);
		return img[addr[11:0]] ^ {addr[23:12], 8'h5a, addr[23:12]};
	endfunction

	initial begin
		for (int i = 0; i < 4096; i++)
			img[i] = $urandom;
		mem_req_ready = 1'b0;
		mem_rsp = '0;
		cycle = 0;
		last_due = 0;
	end

	// accept requests on the rising edge
	always @(posedge clk) begin
		if (reset) begin
			addr_q.delete();
			due_q.delete();
		end else if (mem_req.valid && mem_req_ready) begin
			due = cycle + $urandom_range(1, 6);
			if (due <= last_due)
				due = last_due + 1; // keep request order
			last_due = due;
			addr_q.push_back(mem_req.addr);
			due_q.push_back(due);
		end
	end

	// responses and ready change on the falling edge
	always @(negedge clk) begin
		cycle++;
		mem_req_ready = !reset && ($urandom_range(0, 3) != 0);
		mem_rsp = '0;
		if (due_q.size() > 0 && due_q[0] <= cycle) begin
			mem_rsp.valid = 1'b1;
			mem_rsp.data = word_at(addr_q.pop_front());
			void'(due_q.pop_front());
		end
	end

endmodule

//--- verif/vid_render_tb.sv
// ==========================================================================
// video line renderer testbench
// APB register and RAM traffic, reference pixel model, line buffer
// checker with display line flow control, cycle limit
// ==========================================================================
`timescale 1ns/1ps

module vid_render_tb;
	import vid_regs_pkg::*;
	import vid_bus_pkg::*;

	localparam int H_PIX = 64;
	localparam int V_LIN = 8;
	localparam int FRAME_PIX = H_PIX * V_LIN;
	localparam int TIMEOUT = 3 * 8 * 64 * 4 * 4 + 20000;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [15:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	mem_req_t mem_req;
	logic mem_req_ready;
	mem_rsp_t mem_rsp;
	logic next_field;
	logic [1:0] disp_line;
	lb_wr_t lb_wr;

	// model copies of everything written
	logic [23:0] m_fb_addr;
	logic [15:0] m_pitch;
	logic [1:0] m_layer;
	logic [15:0] m_xoff;
	logic [15:0] m_yoff;
	logic [23:0] m_pal [32];
	logic [5:0] m_map [256];
	logic [31:0] m_tile [512];

	string test_name = "idle";
	int disp_idx = -1; // line on display where -1 is the last line of the previous frame
	int lines_done;
	int wr_count;
	int exp_line;
	int exp_x;
	int cycles;
	int apb_errors;
	int pixel_errors;
	int flow_errors;

	vid_tb_clock clk0 (.clk(clk), .reset(reset));

	vid_tb_mem mem0 (
		.clk(clk), .reset(reset),
		.mem_req(mem_req), .mem_req_ready(mem_req_ready), .mem_rsp(mem_rsp)
	);

	vid_render_top #(.H_PIXELS(H_PIX), .V_LINES(V_LIN), .FIFO_DEPTH(4)) dut0 (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.mem_req(mem_req), .mem_req_ready(mem_req_ready), .mem_rsp(mem_rsp),
		.next_field(next_field), .disp_line(disp_line), .lb_wr(lb_wr)
	);

	assign disp_line = 2'(disp_idx);

	// one APB access with setup phase and access phase until pready
	task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int waits;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		waits = 0;
		@(posedge clk);
		while (!pready) begin
			waits++;
			@(posedge clk);
		end
		if (waits != 1) begin
			$display("access to %h took %0d wait states instead of one", addr, waits);
			apb_errors++;
		end
		rdata = prdata;
		err = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic write_ok(input logic [15:0] addr, input logic [31:0] data);
		logic [31:0] r;
		logic err;
		apb_xfer(1'b1, addr, data, r, err);
		if (err) begin
			$display("unexpected slave error on write to %h", addr);
			apb_errors++;
		end
	endtask

	task automatic read_check(input string name, input logic [15:0] addr,
		input logic [31:0] expected);
		logic [31:0] r;
		logic err;
		apb_xfer(1'b0, addr, 32'h0, r, err);
		if (err) begin
			$display("unexpected slave error on read of %h", addr);
			apb_errors++;
		end
		if (r !== expected) begin
			$display("FAIL %s expected %h actual %h", name, expected, r);
			apb_errors++;
		end
	endtask

	task automatic expect_error(input logic wr, input logic [15:0] addr);
		logic [31:0] r;
		logic err;
		apb_xfer(wr, addr, $urandom, r, err);
		if (err !== 1'b1) begin
			$display("no slave error for access to %h", addr);
			apb_errors++;
		end
	endtask

	task automatic set_reg(input int idx, input logic [31:0] data);
		write_ok(16'(4 * idx), data);
		case (idx)
			REG_FB_ADDR: m_fb_addr = data[23:0];
			REG_FB_PITCH: m_pitch = data[15:0];
			REG_LAYER_EN: m_layer = data[1:0];
			REG_TILE_OFF: begin
				m_xoff = data[15:0];
				m_yoff = data[31:16];
			end
			default: ;
		endcase
	endtask

	task automatic check_regs();
		read_check("reg_fb_addr", 16'h0000, {8'h0, m_fb_addr});
		read_check("reg_pitch", 16'h0004, {16'h0, m_pitch});
		read_check("reg_layer_en", 16'h0008, {30'h0, m_layer});
		read_check("reg_tile_off", 16'h000c, {m_yoff, m_xoff});
		read_check("vidpos_idle", 16'h0010, 32'h0008_0000); // line 8, x 0
	endtask

	task automatic readback_test();
		logic [31:0] d;
		set_reg(REG_FB_ADDR, $urandom);
		set_reg(REG_FB_PITCH, $urandom);
		set_reg(REG_LAYER_EN, $urandom);
		set_reg(REG_TILE_OFF, $urandom);
		check_regs();
		for (int i = 0; i < 32; i++) begin
			d = $urandom;
			write_ok(BASE_PALETTE + 16'(4 * i), d);
			m_pal[i] = d[23:0];
		end
		for (int i = 0; i < 256; i++) begin
			d = $urandom;
			write_ok(BASE_TILEMAP + 16'(4 * i), d);
			m_map[i] = d[5:0]; // upper bits dropped
		end
		for (int i = 0; i < 512; i++) begin
			d = $urandom;
			write_ok(BASE_TILEMEM + 16'(4 * i), d);
			m_tile[i] = d;
		end
		for (int i = 0; i < 32; i++)
			read_check("palette", BASE_PALETTE + 16'(4 * i), {8'h0, m_pal[i]});
		for (int i = 0; i < 256; i++)
			read_check("tilemap", BASE_TILEMAP + 16'(4 * i), {26'h0, m_map[i]});
		for (int i = 0; i < 512; i++)
			read_check("tilemem", BASE_TILEMEM + 16'(4 * i), m_tile[i]);
	endtask

	task automatic error_test();
		expect_error(1'b1, 16'h0010); // VIDPOS is read only
		expect_error(1'b1, 16'h0014);
		expect_error(1'b0, 16'h0014);
		expect_error(1'b1, 16'h1080); // past palette end and aliasing entry 0
		expect_error(1'b1, 16'h2400);
		expect_error(1'b1, 16'h4800);
		expect_error(1'b0, 16'hc000);
		check_regs();
		read_check("palette_kept", BASE_PALETTE, {8'h0, m_pal[0]});
		read_check("tilemap_kept", BASE_TILEMAP, {26'h0, m_map[0]});
		read_check("tilemem_kept", BASE_TILEMEM, m_tile[0]);
	endtask

	// reference pixel from the compositing rule
	function automatic logic [23:0] expected_rgb(input int line, input int x);
		logic [23:0] waddr;
		logic [31:0] fw;
		logic [3:0] fb_nib;
		logic [15:0] tx;
		logic [15:0] ty;
		logic [5:0] tno;
		logic [31:0] row;
		logic [3:0] tile_nib;
		waddr = m_fb_addr + 24'(line) * m_pitch + 24'(x / 8);
		fw = mem0.word_at(waddr);
		fb_nib = fw[4 * (x % 8) +: 4];
		tx = 16'(x) + m_xoff;
		ty = 16'(line) + m_yoff;
		tno = m_map[((ty / 8) % 16) * 16 + (tx / 8) % 16]; // map wraps
		row = m_tile[tno * 8 + ty % 8];
		tile_nib = row[4 * (tx % 8) +: 4];
		if (m_layer[1] && tile_nib != 4'd0)
			return m_pal[16 + tile_nib];
		else if (m_layer[0])
			return m_pal[fb_nib];
		else
			return 24'h0;
	endfunction

	task automatic check_pixel(input lb_wr_t w);
		logic [23:0] exp_rgb;
		if (exp_line >= V_LIN) begin
			$display("pixel write after the end of the frame, line %0d x %0d", w.line, w.x);
			pixel_errors++;
		end else if (w.line != exp_line || w.x != exp_x) begin
			$display("FAIL %s position expected %0d/%0d actual %0d/%0d",
				test_name, exp_line, exp_x, w.line, w.x);
			pixel_errors++;
		end else begin
			exp_rgb = expected_rgb(exp_line, exp_x);
			if (w.rgb !== exp_rgb) begin
				$display("FAIL %s line %0d x %0d expected %h actual %h",
					test_name, exp_line, exp_x, exp_rgb, w.rgb);
				pixel_errors++;
			end
			if (w.line[1:0] == disp_line) begin
				$display("line %0d written while it is on display", w.line);
				flow_errors++;
			end
		end
		wr_count++;
		exp_x++;
		if (exp_x == H_PIX) begin
			exp_x = 0;
			exp_line++;
			lines_done++;
		end
	endtask

	always @(posedge clk) begin
		if (!reset && lb_wr.valid)
			check_pixel(lb_wr);
	end

	// display moves on slowly and only to lines already finished
	always @(negedge clk) begin
		if (!reset && disp_idx + 1 < lines_done && $urandom_range(0, 511) == 0)
			disp_idx++;
	end

	task automatic run_frame(input string name);
		int mid;
		mid = $urandom_range(20, FRAME_PIX - 32);
		test_name = name;
		lines_done = 0;
		disp_idx = -1;
		wr_count = 0;
		exp_line = 0;
		exp_x = 0;
		@(negedge clk);
		next_field = 1'b1;
		@(negedge clk);
		next_field = 1'b0;
		while (wr_count < mid)
			@(negedge clk);
		next_field = 1'b1; // mid-frame pulse that must be ignored
		@(negedge clk);
		next_field = 1'b0;
		while (wr_count < FRAME_PIX || disp_idx < V_LIN - 1)
			@(negedge clk);
		repeat (40) @(negedge clk);
		if (wr_count != FRAME_PIX) begin
			$display("FAIL %s frame writes expected %0d actual %0d", name, FRAME_PIX, wr_count);
			flow_errors++;
		end
		read_check("vidpos_end", 16'h0010, 32'h0008_0000);
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("run stopped at the cycle limit of %0d", TIMEOUT);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		void'($urandom(51740));
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		next_field = 1'b0;
		@(negedge clk);
		while (reset)
			@(negedge clk);
		read_check("reset_fb_addr", 16'h0000, 32'h0);
		read_check("reset_pitch", 16'h0004, 32'(H_PIX / 8));
		read_check("reset_layer_en", 16'h0008, 32'h0);
		readback_test();
		error_test();

		set_reg(REG_LAYER_EN, 32'h1); // framebuffer only
		set_reg(REG_FB_PITCH, $urandom);
		set_reg(REG_FB_ADDR, $urandom);
		run_frame("fb_only");

		set_reg(REG_LAYER_EN, 32'h3);
		set_reg(REG_TILE_OFF, $urandom | 32'h007c_0070); // both map wraps inside the frame
		set_reg(REG_FB_ADDR, $urandom);
		run_frame("tile_layer");

		set_reg(REG_LAYER_EN, 32'h0);
		run_frame("layers_off");

		$display("errors: apb %0d pixel %0d flow %0d", apb_errors, pixel_errors, flow_errors);
		if (apb_errors + pixel_errors + flow_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- src.f
common/vid_regs_pkg.sv
common/vid_bus_pkg.sv
source/vid_dpram.sv
source/vid_apb_regs.sv
fb_fetch/fb_fetch.sv
source/vid_word_fifo.sv
line_render/line_render.sv
source/vid_render_top.sv
verif/vid_tb_clock.sv
verif/vid_tb_mem.sv
verif/vid_render_tb.sv
